/* design/spi_cfg.svh */
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// Frame length in bits for one chip select window
`define SPI_WIDTH 32

// CLK50MHZ cycles per half period of the serial clock
// 1 gives a 25 MHz serial clock
`define SPI_DIV 1

`endif

/* design/spi_pkg.sv */
`include "spi_cfg.svh"

package spi_pkg;

	// One full SPI frame
	typedef logic [`SPI_WIDTH-1:0] spi_word_t;

	// DAC command fields
	typedef logic [3:0]  dac_cmd_t;
	typedef logic [3:0]  dac_addr_t;
	typedef logic [11:0] dac_value_t;

	// DAC frame layout, MSB first on the wire
	typedef struct packed {
		logic [7:0] unused_hi;
		dac_cmd_t   cmd;
		dac_addr_t  addr;
		dac_value_t value;
		logic [3:0] unused_lo;
	} dac_frame_t;

	// Built by fields, shifted as raw bits
	typedef union packed {
		spi_word_t  raw;
		dac_frame_t fields;
	} dac_frame_u;

endpackage

/* design/spi_xfer_if.sv */
`timescale 1ns/1ps

interface spi_xfer_if;
	import spi_pkg::*;

	spi_word_t tx_word;
	spi_word_t rx_word;
	logic      trig;
	logic      done;

	// User side of the shift engine
	modport requester (
		output tx_word,
		output trig,
		input  rx_word,
		input  done
	);

	modport engine (
		input  tx_word,
		input  trig,
		output rx_word,
		output done
	);

endinterface

/* design/spi_clk_gen.sv */
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_clk_gen (
	input  logic CLK50MHZ,
	input  logic RST,
	output logic clk_hf,
	output logic clk_pos_trig,
	output logic clk_neg_trig
);

	// Counter needs at least one bit even for a divider of 1
	localparam int CNT_W = ($clog2(`SPI_DIV) > 0) ? $clog2(`SPI_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SPI_DIV - 1);

	logic [CNT_W-1:0] div_cnt;
	logic             level;
	logic             half_done;

	assign half_done = (div_cnt == CNT_LAST);
	assign clk_hf    = level;

	// Strobes are registered so they line up with the level change
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			div_cnt      <= '0;
			level        <= 1'b0;
			clk_pos_trig <= 1'b0;
			clk_neg_trig <= 1'b0;
		end else begin
			clk_pos_trig <= half_done & ~level;
			clk_neg_trig <= half_done & level;
			if (half_done) begin
				div_cnt <= '0;
				level   <= ~level;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

/* design/spi_shifter.sv */
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_shifter (
	input  logic             CLK50MHZ,
	input  logic             RST,
	input  logic             clk_hf,
	input  logic             clk_pos_trig,
	input  logic             clk_neg_trig,
	spi_xfer_if.engine       xfer,
	output logic             spi_sck,
	output logic             spi_cs,
	output logic             spi_mosi,
	input  logic             spi_miso
);
	import spi_pkg::*;

	localparam int IDX_W = $clog2(`SPI_WIDTH + 2);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`SPI_WIDTH + 1);
	localparam logic [IDX_W-1:0] DATA_IDX = IDX_W'(`SPI_WIDTH);

	localparam logic [1:0] ST_WAIT = 2'd0;
	localparam logic [1:0] ST_SEND = 2'd1;
	localparam logic [1:0] ST_DONE = 2'd2;

	logic [1:0]       state;
	logic [IDX_W-1:0] shift_idx;
	spi_word_t        shift_reg;
	logic             sck_en;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= ST_WAIT;
		end else begin
			case (state)
				ST_WAIT: if (xfer.trig) state <= ST_SEND;
				ST_SEND: if (clk_pos_trig && shift_idx == LAST_IDX) state <= ST_DONE;
				default: state <= ST_WAIT;
			endcase
		end
	end

	// Counts rising strobes inside the frame
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			shift_idx <= '0;
		end else if (state != ST_SEND) begin
			shift_idx <= '0;
		end else if (clk_pos_trig) begin
			if (shift_idx <= DATA_IDX)
				shift_idx <= shift_idx + 1'b1;
			else
				shift_idx <= '0;
		end
	end

	// Decided on the falling strobe so every sck pulse is a full high phase
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			sck_en <= 1'b0;
		end else if (state != ST_SEND) begin
			sck_en <= 1'b0;
		end else if (clk_neg_trig) begin
			sck_en <= (shift_idx >= IDX_W'(2)) && (shift_idx <= LAST_IDX);
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			spi_cs <= 1'b1;
		else if (xfer.trig)
			spi_cs <= 1'b0;
		else if (xfer.done)
			spi_cs <= 1'b1;
	end

	////////////////////////////////////////
	// Data path
	////////////////////////////////////////

	// MISO enters at the LSB as the MSB leaves on MOSI
	always_ff @(posedge CLK50MHZ) begin
		if (state == ST_WAIT) begin
			if (xfer.trig)
				shift_reg <= xfer.tx_word;
		end else if (state == ST_SEND && clk_pos_trig && shift_idx != '0) begin
			shift_reg <= {shift_reg[`SPI_WIDTH-2:0], spi_miso};
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			spi_mosi <= 1'b0;
		else if (state == ST_WAIT)
			spi_mosi <= 1'b0;
		else if (state == ST_SEND && clk_pos_trig && shift_idx != '0)
			spi_mosi <= shift_reg[`SPI_WIDTH-1];
	end

	assign spi_sck      = clk_hf & sck_en & (state == ST_SEND);
	assign xfer.rx_word = shift_reg;
	assign xfer.done    = (state == ST_DONE);

endmodule

/* design/dac_cmd_req.sv */
`timescale 1ns/1ps

module dac_cmd_req (
	input  logic                 CLK50MHZ,
	input  logic                 RST,
	input  logic                 req,
	output logic                 ack,
	input  spi_pkg::dac_cmd_t    cmd,
	input  spi_pkg::dac_addr_t   addr,
	input  spi_pkg::dac_value_t  value,
	output spi_pkg::spi_word_t   readback,
	spi_xfer_if.requester        xfer
);
	import spi_pkg::*;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_BUSY = 2'd1;
	localparam logic [1:0] ST_ACK  = 2'd2;

	logic [1:0] state;
	logic       trig_pulse;
	dac_frame_u frame;

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state      <= ST_IDLE;
			trig_pulse <= 1'b0;
			ack        <= 1'b0;
			readback   <= '0;
		end else begin
			trig_pulse <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req) begin
						trig_pulse <= 1'b1;
						state      <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					if (xfer.done) begin
						readback <= xfer.rx_word;
						ack      <= 1'b1;
						state    <= ST_ACK;
					end
				end
				default: begin
					// Held until the host lets go of req
					if (!req) begin
						ack   <= 1'b0;
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// Frame is captured with the trig so tx_word is stable for the engine
	always_ff @(posedge CLK50MHZ) begin
		if (state == ST_IDLE && req) begin
			frame.fields.unused_hi <= '0;
			frame.fields.cmd       <= cmd;
			frame.fields.addr      <= addr;
			frame.fields.value     <= value;
			frame.fields.unused_lo <= '0;
		end
	end

	assign xfer.trig    = trig_pulse;
	assign xfer.tx_word = frame.raw;

endmodule

/* design/spi_dac_top.sv */
`timescale 1ns/1ps

module spi_dac_top (
	input  logic                 CLK50MHZ,
	input  logic                 RST,
	input  logic                 req,
	output logic                 ack,
	input  spi_pkg::dac_cmd_t    cmd,
	input  spi_pkg::dac_addr_t   addr,
	input  spi_pkg::dac_value_t  value,
	output spi_pkg::spi_word_t   readback,
	output logic                 spi_sck,
	output logic                 spi_cs,
	output logic                 spi_mosi,
	input  logic                 spi_miso
);

	logic clk_hf;
	logic clk_pos_trig;
	logic clk_neg_trig;

	spi_xfer_if u_xfer ();

	dac_cmd_req u_dac_cmd_req (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.req      (req),
		.ack      (ack),
		.cmd      (cmd),
		.addr     (addr),
		.value    (value),
		.readback (readback),
		.xfer     (u_xfer.requester)
	);

	spi_clk_gen u_spi_clk_gen (
		.CLK50MHZ     (CLK50MHZ),
		.RST          (RST),
		.clk_hf       (clk_hf),
		.clk_pos_trig (clk_pos_trig),
		.clk_neg_trig (clk_neg_trig)
	);

	spi_shifter u_spi_shifter (
		.CLK50MHZ     (CLK50MHZ),
		.RST          (RST),
		.clk_hf       (clk_hf),
		.clk_pos_trig (clk_pos_trig),
		.clk_neg_trig (clk_neg_trig),
		.xfer         (u_xfer.engine),
		.spi_sck      (spi_sck),
		.spi_cs       (spi_cs),
		.spi_mosi     (spi_mosi),
		.spi_miso     (spi_miso)
	);

endmodule

/* tb/spi_dac_model.sv */
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_dac_model (
	input  logic               spi_sck,
	input  logic               spi_cs,
	input  logic               spi_mosi,
	output logic               spi_miso,
	output spi_pkg::spi_word_t last_frame,
	output int                 last_edges,
	output int                 total_edges
);
	import spi_pkg::*;

	spi_word_t rx_shift;
	spi_word_t tx_shift;
	spi_word_t echo_word;
	int        frame_edges;
	logic      in_frame;

	initial begin
		rx_shift    = '0;
		tx_shift    = '0;
		echo_word   = '0;
		frame_edges = 0;
		in_frame    = 1'b0;
		last_frame  = '0;
		last_edges  = 0;
		total_edges = 0;
	end

	// MSB of the echo word is always on the line
	assign spi_miso = tx_shift[`SPI_WIDTH-1];

	// Start of frame loads the previous frame for echo
	always @(negedge spi_cs) begin
		tx_shift    = echo_word;
		frame_edges = 0;
		in_frame    = 1'b1;
	end

	// Total counts every rising sck, inside a frame or not
	always @(posedge spi_sck) begin
		total_edges = total_edges + 1;
		if (in_frame) begin
			rx_shift    = {rx_shift[`SPI_WIDTH-2:0], spi_mosi};
			frame_edges = frame_edges + 1;
		end
	end

	// Next MISO bit after the host has sampled
	always @(negedge spi_sck) begin
		if (in_frame)
			tx_shift = {tx_shift[`SPI_WIDTH-2:0], 1'b0};
	end

	always @(posedge spi_cs) begin
		if (in_frame) begin
			last_frame = rx_shift;
			last_edges = frame_edges;
			echo_word  = rx_shift;
			in_frame   = 1'b0;
		end
	end

endmodule

/* tb/tb_spi_dac_top.sv */
`timescale 1ns/1ps
`include "spi_cfg.svh"

module tb_spi_dac_top;
	import spi_pkg::*;

	localparam int NUM_XFERS   = 25;
	localparam int HOLD_CYCLES = 200;
	localparam int XFER_CYCLES = 2 * `SPI_DIV * (`SPI_WIDTH + 4) + 20;
	localparam int CYCLE_LIMIT = NUM_XFERS * XFER_CYCLES + HOLD_CYCLES + 20;

	logic       CLK50MHZ;
	logic       RST;
	logic       req;
	logic       ack;
	dac_cmd_t   cmd;
	dac_addr_t  addr;
	dac_value_t value;
	spi_word_t  readback;
	logic       spi_sck;
	logic       spi_cs;
	logic       spi_mosi;
	logic       spi_miso;
	spi_word_t  last_frame;
	int         last_edges;
	int         total_edges;

	int         cycle_cnt = 0;
	integer     seed = 32'h549b;
	spi_word_t  prev_frame;

	spi_dac_top u_spi_dac_top (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.req      (req),
		.ack      (ack),
		.cmd      (cmd),
		.addr     (addr),
		.value    (value),
		.readback (readback),
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	spi_dac_model u_spi_dac_model (
		.spi_sck     (spi_sck),
		.spi_cs      (spi_cs),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso),
		.last_frame  (last_frame),
		.last_edges  (last_edges),
		.total_edges (total_edges)
	);

	always #10 CLK50MHZ = ~CLK50MHZ;

	always @(posedge CLK50MHZ) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			abort_run($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
	end

	////////////////////////////////////////
	// Reporting and compares
	////////////////////////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "Run stopped on first error");
	endtask

	task automatic check_word(input string name, input spi_word_t got, input spi_word_t exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Eight zero bits, cmd, addr, value, four zero bits
	function automatic spi_word_t expected_frame(input dac_cmd_t c, input dac_addr_t a,
		input dac_value_t v);
		return {8'h00, c, a, v, 4'h0};
	endfunction

	////////////////////////////////////////
	// Handshake steps
	////////////////////////////////////////

	task automatic send_request(input dac_cmd_t c, input dac_addr_t a, input dac_value_t v);
		@(posedge CLK50MHZ);
		cmd   <= c;
		addr  <= a;
		value <= v;
		req   <= 1'b1;
	endtask

	// cs must stay low from its fall until ack
	task automatic wait_for_ack();
		bit cs_seen_low;
		cs_seen_low = 1'b0;
		do begin
			@(negedge CLK50MHZ);
			if (spi_cs === 1'b0)
				cs_seen_low = 1'b1;
			else if (cs_seen_low && ack !== 1'b1)
				abort_run("Chip select went high before the frame was acknowledged");
		end while (ack !== 1'b1);
		if (!cs_seen_low)
			abort_run("Chip select never went low during the transfer");
		check_bit("spi_cs", spi_cs, 1'b1);
	endtask

	task automatic release_request();
		@(posedge CLK50MHZ);
		req <= 1'b0;
		@(negedge CLK50MHZ);
		check_bit("ack", ack, 1'b1);
		@(negedge CLK50MHZ);
		check_bit("ack", ack, 1'b0);
	endtask

	task automatic check_transfer(input spi_word_t exp);
		check_word("captured frame", last_frame, exp);
		check_count("sck rising edges", last_edges, `SPI_WIDTH);
		check_word("readback", readback, prev_frame);
		prev_frame = exp;
	endtask

	task automatic run_command(input dac_cmd_t c, input dac_addr_t a, input dac_value_t v);
		send_request(c, a, v);
		wait_for_ack();
		check_transfer(expected_frame(c, a, v));
		release_request();
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset_values();
		@(negedge CLK50MHZ);
		check_bit("spi_cs", spi_cs, 1'b1);
		check_bit("spi_sck", spi_sck, 1'b0);
		check_bit("spi_mosi", spi_mosi, 1'b0);
		check_bit("ack", ack, 1'b0);
		check_word("readback", readback, '0);
	endtask

	task automatic test_single_write();
		run_command(4'h3, 4'h5, 12'habc);
		check_word("captured frame", last_frame, 32'h0035_abc0);
	endtask

	task automatic test_echo();
		run_command(4'h1, 4'h2, 12'h345);
		run_command(4'hc, 4'h9, 12'h0f0);
	endtask

	task automatic test_framing();
		int edges_before;
		edges_before = total_edges;
		run_command(4'hf, 4'hf, 12'hfff);
		check_count("total sck edges", total_edges, edges_before + `SPI_WIDTH);
		check_bit("spi_sck", spi_sck, 1'b0);
	endtask

	// req stays high after ack, no second frame may start
	task automatic test_hold();
		int edges_before;
		send_request(4'h6, 4'ha, 12'h5a5);
		wait_for_ack();
		check_transfer(expected_frame(4'h6, 4'ha, 12'h5a5));
		edges_before = total_edges;
		repeat (HOLD_CYCLES) begin
			@(negedge CLK50MHZ);
			check_bit("ack", ack, 1'b1);
			check_bit("spi_cs", spi_cs, 1'b1);
		end
		check_count("total sck edges", total_edges, edges_before);
		release_request();
	endtask

	task automatic test_random();
		logic [31:0] r;
		for (int i = 0; i < 20; i++) begin
			r = $random(seed);
			run_command(r[3:0], r[7:4], r[19:8]);
		end
	endtask

	initial begin
		CLK50MHZ   = 1'b0;
		RST        = 1'b1;
		req        = 1'b0;
		cmd        = '0;
		addr       = '0;
		value      = '0;
		prev_frame = '0;
		repeat (5) @(posedge CLK50MHZ);
		RST <= 1'b0;

		test_reset_values();
		test_single_write();
		test_echo();
		test_framing();
		test_hold();
		test_random();

		$display("=== PASS ===");
		$finish;
	end

endmodule

/* build.f */
+incdir+design
design/spi_pkg.sv
design/spi_xfer_if.sv
design/spi_clk_gen.sv
design/spi_shifter.sv
design/dac_cmd_req.sv
design/spi_dac_top.sv
tb/spi_dac_model.sv
tb/tb_spi_dac_top.sv

/* Bender.yml */
package:
  name: spi_dac

sources:
  - include_dirs:
      - design
    files:
      - design/spi_pkg.sv
      - design/spi_xfer_if.sv
      - design/spi_clk_gen.sv
      - design/spi_shifter.sv
      - design/dac_cmd_req.sv
      - design/spi_dac_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/spi_dac_model.sv
      - tb/tb_spi_dac_top.sv
